//--- Makefile
# Verilator build and run of the converter testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_fp_converter
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), result taken from $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "FAIL: no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+include
src/fpc_format_pkg.sv
src/fpc_op_pkg.sv
src/fpc_unpack.sv
src/fpc_convert.sv
src/fpc_round_pack.sv
src/fp_converter.sv
test/tb_fp_converter.sv

//--- src/fp_converter.sv
/* Converter top: three-stage pipeline of unpack, convert
   and round/pack, plus the busy indication */
`timescale 1ns/10ps

module fp_converter #(
  parameter int XLEN = 64
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start,
  input  fpc_op_pkg::fpc_op_e     op,
  input  fpc_op_pkg::round_mode_e rm,
  input  logic [XLEN-1:0]         int_operand,
  input  logic [63:0]             fp_operand,
  output logic                    done,
  output logic                    busy,
  output logic [XLEN-1:0]         int_result,
  output logic [63:0]             fp_result,
  output logic                    flag_nv,
  output logic                    flag_nx
);
  import fpc_op_pkg::*;

  fpc_req_t    req;           // Stage 1 register
  fpc_mid_t    mid;           // Stage 2 register
  logic [63:0] int_result_w;

  fpc_unpack #(.XLEN(XLEN)) u_unpack (
    .clk         (clk),
    .reset_n     (reset_n),
    .start       (start),
    .op          (op),
    .rm          (rm),
    .int_operand (int_operand),
    .fp_operand  (fp_operand),
    .req         (req)
  );

  fpc_convert #(.XLEN(XLEN)) u_convert (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .mid     (mid)
  );

  fpc_round_pack u_round_pack (
    .clk        (clk),
    .reset_n    (reset_n),
    .mid        (mid),
    .done       (done),
    .int_result (int_result_w),
    .fp_result  (fp_result),
    .flag_nv    (flag_nv),
    .flag_nx    (flag_nx)
  );

  assign int_result = int_result_w[XLEN-1:0];     // Low word on RV32
  assign busy       = req.valid || mid.valid || done;  // Any stage occupied

endmodule

//--- src/fpc_convert.sv
/* Stage 2 of the converter: leading one search for int to float,
   float to int shift with saturation, single and double resizing */
`timescale 1ns/10ps

module fpc_convert #(
  parameter int XLEN = 64
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fpc_op_pkg::fpc_req_t req,
  output fpc_op_pkg::fpc_mid_t mid
);
  import fpc_format_pkg::*;
  import fpc_op_pkg::*;

  localparam int REBIAS = D_BIAS - S_BIAS;  // 896

  fpc_mid_t mid_d;

  // Int to float
  logic [5:0]         msb;
  logic [63:0]        norm;
  // Float to int
  fp_s_t              fs;
  logic signed [9:0]  ue;                   // Unbiased exponent
  logic signed [9:0]  max_ue;
  logic               min_edge;
  logic [127:0]       fix_sh;               // 64.64 fixed point
  logic [63:0]        f2i_mag;
  logic [63:0]        f2i_neg;
  logic [63:0]        f2i_val;
  logic [63:0]        pos_lim;
  logic [63:0]        neg_lim;
  // Double to single
  fp_d_t              fd;
  logic signed [12:0] adj_exp;

  assign fs = req.operand.s.sp;
  assign fd = req.operand.d;

  // Priority count, highest set bit wins
  always_comb begin
    msb = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (req.int_mag[i]) msb = 6'(i);
    end
  end
  assign norm = req.int_mag << (6'd63 - msb);  // Leading one to bit 63

  // ----------------------------
  // Float to int datapath
  // ----------------------------
  assign ue       = $signed({2'b00, fs.exp}) - $signed(10'(S_BIAS));
  assign max_ue   = op_is_64(req.op) ? (req.op[0] ? 10'sd63 : 10'sd62)
                                     : (req.op[0] ? 10'sd31 : 10'sd30);
  assign min_edge = !req.op[0] && fs.sign && (ue == max_ue + 10'sd1) && (fs.man == '0);
  assign fix_sh   = {63'd0, 1'b1, fs.man, 41'd0} << ue[5:0];
  assign f2i_mag  = fix_sh[127:64];
  assign f2i_neg  = (!req.op[0] && fs.sign) ? -f2i_mag : f2i_mag;
  assign f2i_val  = op_is_64(req.op) ? f2i_neg : {{32{f2i_neg[31]}}, f2i_neg[31:0]};

  // Saturation limits, 32-bit ones sign extended
  always_comb begin
    pos_lim = '1;
    neg_lim = '0;
    if (!req.op[0]) begin
      pos_lim = op_is_64(req.op) ? 64'h7FFF_FFFF_FFFF_FFFF : 64'h0000_0000_7FFF_FFFF;
      neg_lim = op_is_64(req.op) ? 64'h8000_0000_0000_0000 : 64'hFFFF_FFFF_8000_0000;
    end
  end

  assign adj_exp = $signed({2'b00, fd.exp}) - $signed(13'(REBIAS));

  always_comb begin
    mid_d = '0;                                 // Idle slots carry nothing
    if (req.valid) begin
      mid_d.valid = 1'b1;
      mid_d.op    = req.op;
      mid_d.rm    = req.rm;
      if (req.illegal) begin
        mid_d.nv     = 1'b1;                    // Rejected, results stay zero
        mid_d.bypass = 1'b1;
      end else if (op_is_i2f(req.op)) begin
        mid_d.sign = req.int_sign;
        if (req.int_mag == '0) begin
          mid_d.bypass     = 1'b1;
          mid_d.bypass_val = {S_BOX, 32'd0};    // Boxed +0
        end else begin
          mid_d.exp    = 11'(S_BIAS) + 11'(msb);
          mid_d.man    = 53'(norm[63:40]);      // Hidden bit and 23 fraction bits
          mid_d.guard  = norm[39];
          mid_d.round  = norm[38];
          mid_d.sticky = |norm[37:0];
        end
      end else if (op_is_f2i(req.op)) begin
        if (req.cls.is_nan || req.cls.is_inf) begin
          mid_d.int_val = fs.sign ? neg_lim : pos_lim;
          mid_d.nv      = 1'b1;
        end else if (req.cls.is_zero) begin
          mid_d.int_val = '0;
        end else if (req.op[0] && fs.sign) begin
          mid_d.nx = 1'b1;                      // Negative to unsigned clamps to 0
        end else if (ue < 0) begin
          mid_d.nx = 1'b1;                      // Pure fraction truncates away
        end else if ((ue > max_ue) && !min_edge) begin
          mid_d.int_val = fs.sign ? neg_lim : pos_lim;
          mid_d.nv      = 1'b1;
        end else begin
          mid_d.int_val = f2i_val;
          mid_d.nx      = |fix_sh[63:0];        // Dropped fraction bits
        end
      end else if (req.op == FCVT_S_D) begin
        mid_d.bypass = 1'b1;
        if (req.cls.is_nan) begin
          mid_d.bypass_val = CANON_NAN_S;
        end else if (req.cls.is_inf) begin
          mid_d.bypass_val = {S_BOX, fd.sign, 8'hFF, 23'd0};
        end else if (req.cls.is_zero) begin
          mid_d.bypass_val = {S_BOX, fd.sign, 31'd0};
        end else if (adj_exp >= 13'sd255) begin
          mid_d.bypass_val = {S_BOX, fd.sign, 8'hFF, 23'd0};  // Overflow to inf
          mid_d.nx         = 1'b1;
        end else if (adj_exp < 13'sd1) begin
          mid_d.bypass_val = {S_BOX, fd.sign, 31'd0};         // Flush to zero
          mid_d.nx         = 1'b1;
        end else begin
          mid_d.bypass_val = {S_BOX, fd.sign, adj_exp[7:0], fd.man[51:29]};
          mid_d.nx         = |fd.man[28:0];                   // Truncated mantissa
        end
      end else if (req.op == FCVT_D_S) begin
        mid_d.bypass = 1'b1;                    // Always exact
        if (req.cls.is_nan) begin
          mid_d.bypass_val = CANON_NAN_D;
        end else if (req.cls.is_inf) begin
          mid_d.bypass_val = {fs.sign, 11'h7FF, 52'd0};
        end else if (req.cls.is_zero) begin
          mid_d.bypass_val = {fs.sign, 63'd0};
        end else begin
          mid_d.bypass_val = {fs.sign, 11'(fs.exp) + 11'(REBIAS), fs.man, 29'd0};
        end
      end else begin
        mid_d.bypass = 1'b1;                    // Unknown op, zero and no flags
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mid <= '0;
    end else begin
      mid <= mid_d;
    end
  end

  a_bypass_valid: assert property (@(posedge clk) disable iff (!reset_n)
    mid.bypass |-> mid.valid);

endmodule

//--- src/fpc_format_pkg.sv
/* IEEE 754 single and double format constants, field structs,
   the operand union read as double or boxed single, canonical NaNs */
package fpc_format_pkg;

  // Field widths and exponent biases
  localparam int S_EXP_W = 8;
  localparam int S_MAN_W = 23;
  localparam int S_BIAS  = 127;
  localparam int D_EXP_W = 11;
  localparam int D_MAN_W = 52;
  localparam int D_BIAS  = 1023;

  localparam logic [31:0] S_BOX = 32'hFFFF_FFFF;  // Upper half of a boxed single

  // ----------------------------
  // Field layouts
  // ----------------------------
  typedef struct packed {
    logic               sign;
    logic [D_EXP_W-1:0] exp;
    logic [D_MAN_W-1:0] man;
  } fp_d_t;

  typedef struct packed {
    logic               sign;
    logic [S_EXP_W-1:0] exp;
    logic [S_MAN_W-1:0] man;
  } fp_s_t;

  typedef struct packed {
    logic [31:0] box;  // All ones when properly boxed
    fp_s_t       sp;
  } fp_s_boxed_t;

  // One 64-bit operand word, decoded by the operation
  typedef union packed {
    fp_d_t       d;
    fp_s_boxed_t s;
  } fp_word_u;

  typedef struct packed {
    logic is_nan;
    logic is_inf;
    logic is_zero;  // Subnormals land here too
  } fp_class_t;

  // Canonical quiet NaNs, single one already boxed
  localparam logic [63:0] CANON_NAN_S = {S_BOX, 32'h7FC0_0000};
  localparam logic [63:0] CANON_NAN_D = 64'h7FF8_0000_0000_0000;

endpackage

//--- src/fpc_op_pkg.sv
/* Conversion opcodes, rounding modes, opcode helpers
   and the request structs passed between pipeline stages */
package fpc_op_pkg;

  // Opcodes as seen by the core
  typedef enum logic [3:0] {
    FCVT_W_S  = 4'b0000,  // Single to int32
    FCVT_WU_S = 4'b0001,  // Single to uint32
    FCVT_L_S  = 4'b0010,  // Single to int64
    FCVT_LU_S = 4'b0011,  // Single to uint64
    FCVT_S_W  = 4'b0100,  // Int32 to single
    FCVT_S_WU = 4'b0101,
    FCVT_S_L  = 4'b0110,
    FCVT_S_LU = 4'b0111,
    FCVT_S_D  = 4'b1000,  // Double to single
    FCVT_D_S  = 4'b1001   // Single to double
  } fpc_op_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,  // Nearest, ties to even
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100   // Nearest, ties away
  } round_mode_e;

  // ----------------------------
  // Opcode groups
  // ----------------------------
  function automatic logic op_is_f2i(fpc_op_e op);
    return op inside {FCVT_W_S, FCVT_WU_S, FCVT_L_S, FCVT_LU_S};
  endfunction

  function automatic logic op_is_i2f(fpc_op_e op);
    return op inside {FCVT_S_W, FCVT_S_WU, FCVT_S_L, FCVT_S_LU};
  endfunction

  function automatic logic op_is_resize(fpc_op_e op);
    return op inside {FCVT_S_D, FCVT_D_S};
  endfunction

  // Needs a 64-bit integer on either side
  function automatic logic op_is_64(fpc_op_e op);
    return op inside {FCVT_L_S, FCVT_LU_S, FCVT_S_L, FCVT_S_LU};
  endfunction

  // Stage 1 to stage 2
  typedef struct packed {
    logic                     valid;
    fpc_op_e                  op;
    round_mode_e              rm;
    logic [63:0]              int_mag;   // Absolute value of the integer
    logic                     int_sign;
    fpc_format_pkg::fp_word_u operand;
    fpc_format_pkg::fp_class_t cls;
    logic                     illegal;   // 64-bit op on a 32-bit core
  } fpc_req_t;

  // Stage 2 to stage 3
  typedef struct packed {
    logic        valid;
    fpc_op_e     op;
    round_mode_e rm;
    logic        sign;
    logic [63:0] int_val;     // Final float-to-int result
    logic [10:0] exp;         // Biased single exponent
    logic [52:0] man;         // Hidden bit plus fraction
    logic        guard;
    logic        round;
    logic        sticky;
    logic        nv;
    logic        nx;
    logic        bypass;      // bypass_val is already final
    logic [63:0] bypass_val;
  } fpc_mid_t;

endpackage

//--- src/fpc_round_pack.sv
/* Stage 3 of the converter: rounding of int to float results,
   single packing with NaN box, output and flag registers */
`timescale 1ns/10ps

module fpc_round_pack (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fpc_op_pkg::fpc_mid_t mid,
  output logic                 done,
  output logic [63:0]          int_result,
  output logic [63:0]          fp_result,
  output logic                 flag_nv,
  output logic                 flag_nx
);
  import fpc_format_pkg::*;
  import fpc_op_pkg::*;

  logic        grs;        // Any bit lost below the mantissa
  logic        round_up;
  logic [24:0] man_sum;
  logic        carry;
  fp_s_boxed_t packed_s;
  logic [63:0] fp_next;
  logic        wr_int;
  logic        wr_fp;

  assign grs = mid.guard | mid.round | mid.sticky;

  // ----------------------------
  // Rounding decision
  // ----------------------------
  always_comb begin
    case (mid.rm)
      RNE:     round_up = mid.guard && (mid.round || mid.sticky || mid.man[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = mid.sign && grs;     // Away from zero only if negative
      RUP:     round_up = !mid.sign && grs;
      RMM:     round_up = mid.guard;
      default: round_up = 1'b0;                // Reserved modes truncate
    endcase
  end

  assign man_sum = {1'b0, mid.man[23:0]} + 25'(round_up);
  assign carry   = man_sum[24];                // 1.111.. rolled over to 10.000..

  // Pack single, bump exponent on carry
  always_comb begin
    packed_s.box     = S_BOX;
    packed_s.sp.sign = mid.sign;
    packed_s.sp.exp  = mid.exp[S_EXP_W-1:0] + 8'(carry);
    packed_s.sp.man  = man_sum[S_MAN_W-1:0];   // Already zero after a carry
  end

  assign fp_next = mid.bypass ? mid.bypass_val : packed_s;

  // Unknown ops write both results, as zero
  assign wr_int = !(op_is_i2f(mid.op) || op_is_resize(mid.op));
  assign wr_fp  = !op_is_f2i(mid.op);

  // ----------------------------
  // Output registers
  // ----------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done       <= 1'b0;
      int_result <= '0;
      fp_result  <= '0;
      flag_nv    <= 1'b0;
      flag_nx    <= 1'b0;
    end else begin
      done    <= mid.valid;                        // One pulse per result
      flag_nv <= mid.valid && mid.nv;              // Flags live with done only
      flag_nx <= mid.valid && (mid.nx || grs);
      if (mid.valid && wr_int) begin
        int_result <= mid.int_val;
      end
      if (mid.valid && wr_fp) begin
        fp_result <= fp_next;                      // Held until next write
      end
    end
  end

  a_nv_with_done: assert property (@(posedge clk) disable iff (!reset_n)
    flag_nv |-> done);

endmodule

//--- src/fpc_unpack.sv
/* Stage 1 of the converter: operand classification,
   integer sign and magnitude, request register */
`timescale 1ns/10ps

module fpc_unpack #(
  parameter int XLEN = 64
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     start,
  input  fpc_op_pkg::fpc_op_e      op,
  input  fpc_op_pkg::round_mode_e  rm,
  input  logic [XLEN-1:0]          int_operand,
  input  fpc_format_pkg::fp_word_u fp_operand,
  output fpc_op_pkg::fpc_req_t     req
);
  import fpc_format_pkg::*;
  import fpc_op_pkg::*;

  logic [63:0] int_ext;
  logic        sign_w;     // Negative 32-bit signed input
  logic        sign_l;
  logic [31:0] mag_w;
  logic [63:0] mag_l;
  logic [63:0] int_mag;
  logic        int_sign;
  fp_class_t   cls;
  logic        illegal;

  // ----------------------------
  // Integer side
  // ----------------------------
  assign int_ext  = 64'(int_operand);                     // Zero fill on RV32
  assign sign_w   = !op[0] && int_ext[31];                // op[0] set means unsigned
  assign sign_l   = !op[0] && int_ext[63];
  assign mag_w    = sign_w ? -int_ext[31:0] : int_ext[31:0];
  assign mag_l    = sign_l ? -int_ext : int_ext;
  assign int_sign = op_is_64(op) ? sign_l : sign_w;
  assign int_mag  = op_is_64(op) ? mag_l : {32'd0, mag_w};
  assign illegal  = (XLEN == 32) && op_is_64(op);         // No 64-bit ints on RV32

  // ----------------------------
  // Float side
  // ----------------------------
  always_comb begin
    if (op == FCVT_S_D) begin
      // Double fields
      cls.is_nan  = (fp_operand.d.exp == '1) && (fp_operand.d.man != '0);
      cls.is_inf  = (fp_operand.d.exp == '1) && (fp_operand.d.man == '0);
      cls.is_zero = (fp_operand.d.exp == '0);
    end else begin
      // Boxed single fields, also used by float to int
      cls.is_nan  = (fp_operand.s.sp.exp == '1) && (fp_operand.s.sp.man != '0);
      cls.is_inf  = (fp_operand.s.sp.exp == '1) && (fp_operand.s.sp.man == '0);
      cls.is_zero = (fp_operand.s.sp.exp == '0);        // Denormals flushed
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req <= '0;
    end else begin
      req.valid <= start;
      if (start) begin                                  // Hold payload otherwise
        req.op       <= op;
        req.rm       <= rm;
        req.int_mag  <= int_mag;
        req.int_sign <= int_sign;
        req.operand  <= fp_operand;
        req.cls      <= cls;
        req.illegal  <= illegal;
      end
    end
  end

  // Core must only issue defined opcodes
  a_known_op: assert property (@(posedge clk) disable iff (!reset_n)
    start |-> (op inside {[FCVT_W_S:FCVT_D_S]}));

endmodule

//--- include/fpc_tb_checks.svh
/* Testbench compare tasks for results, flags, strobes and latency,
   plus the Galois LFSR behind the random operands */
`ifndef FPC_TB_CHECKS_SVH
`define FPC_TB_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_fp(input fp_word_u got, input fp_word_u want, input string what);
  if (got !== want) begin
    $display("** Error @ %0t: %s fp_result %h, expected %h", $time, what, got, want);
    $display("   single view s=%b e=%h m=%h, double view s=%b e=%h m=%h",
             got.s.sp.sign, got.s.sp.exp, got.s.sp.man, got.d.sign, got.d.exp, got.d.man);
    stop_with_failure();
  end
endtask

task automatic check_int(input logic [63:0] got, input logic [63:0] want, input string what);
  if (got !== want) begin
    $display("** Error @ %0t: %s int_result %h, expected %h", $time, what, got, want);
    stop_with_failure();
  end
endtask

task automatic check_flags(input logic got_nv, input logic got_nx,
                           input logic want_nv, input logic want_nx, input string what);
  if ({got_nv, got_nx} !== {want_nv, want_nx}) begin
    $display("** Error @ %0t: %s flags nv=%b nx=%b, expected nv=%b nx=%b",
             $time, what, got_nv, got_nx, want_nv, want_nx);
    stop_with_failure();
  end
endtask

// done and busy together
task automatic check_strobes(input logic got_done, input logic got_busy,
                             input logic want_done, input logic want_busy, input string what);
  if ({got_done, got_busy} !== {want_done, want_busy}) begin
    $display("** Error @ %0t: %s done=%b busy=%b, expected done=%b busy=%b",
             $time, what, got_done, got_busy, want_done, want_busy);
    stop_with_failure();
  end
endtask

task automatic check_latency(input int got, input int want, input string what);
  if (got != want) begin
    $display("** Error @ %0t: %s took %0d cycles, expected %0d", $time, what, got, want);
    stop_with_failure();
  end
endtask

// ------------------------------
// Random source
// ------------------------------
logic [31:0] lfsr_state = 32'hBBFB;

// Right-shift Galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] rand_bits(input int count);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < count; i++) begin
    val        = {val[30:0], lfsr_state[0]};                        // One step per bit
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return val;
endfunction

`endif

//--- test/tb_fp_converter.sv
/* Testbench for the conversion pipeline: clock, reset, timeout,
   latency monitor and the directed conversion tests */
`timescale 1ns/10ps

module tb_fp_converter;
  import fpc_format_pkg::*;
  import fpc_op_pkg::*;

  localparam int XLEN           = 64;
  localparam int TIMEOUT_CYCLES = 400;  // About 240 cycles of tests plus margin

  logic            clk;
  logic            reset_n;
  logic            start;
  fpc_op_e         op;
  round_mode_e     rm;
  logic [XLEN-1:0] int_operand;
  logic [63:0]     fp_operand;
  logic            done;
  logic            busy;
  logic [XLEN-1:0] int_result;
  logic [63:0]     fp_result;
  logic            flag_nv;
  logic            flag_nx;

  int cycles = 0;      // Rising edges since time zero
  int start_q[$];      // Edge count of each accepted start

  `include "fpc_tb_checks.svh"

  fp_converter #(.XLEN(XLEN)) dut (.*);

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle count, run limit, start bookkeeping
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end else if (reset_n && start) begin
      start_q.push_back(cycles);
    end
  end

  // Every done must come 3 edges after the edge that drove its start
  always @(negedge clk) begin
    if (reset_n && done) begin
      if (start_q.size() == 0) begin
        $display("A done pulse came with no request in flight");
        stop_with_failure();
      end else begin
        check_latency(cycles - start_q.pop_front(), 3, "start to done");
      end
    end
  end

  // ------------------------------
  // Drive helpers
  // ------------------------------
  function automatic logic [63:0] boxed(input logic [31:0] single);
    return {32'hFFFF_FFFF, single};
  endfunction

  // Exact tie with an even truncated mantissa, so RNE stays down
  function automatic logic tie_away(input logic neg, input round_mode_e mode);
    case (mode)
      RDN:     return neg;
      RUP:     return !neg;
      RMM:     return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic drive_req(input fpc_op_e code, input round_mode_e mode,
                           input logic [63:0] ival, input logic [63:0] fval);
    @(posedge clk);
    start       <= 1'b1;
    op          <= code;
    rm          <= mode;
    int_operand <= ival;
    fp_operand  <= fval;
  endtask

  task automatic convert(input fpc_op_e code, input round_mode_e mode,
                         input logic [63:0] ival, input logic [63:0] fval);
    drive_req(code, mode, ival, fval);
    @(posedge clk);
    start <= 1'b0;
    do @(negedge clk); while (!done);    // Wait for the result
  endtask

  task automatic run_fp(input fpc_op_e code, input round_mode_e mode, input logic [63:0] ival,
                        input logic [63:0] fval, input logic [63:0] want,
                        input logic want_nv, input logic want_nx, input string what);
    convert(code, mode, ival, fval);
    check_fp(fp_result, want, what);
    check_flags(flag_nv, flag_nx, want_nv, want_nx, what);
  endtask

  task automatic run_int(input fpc_op_e code, input logic [63:0] fval, input logic [63:0] want,
                         input logic want_nv, input logic want_nx, input string what);
    convert(code, RTZ, 64'd0, fval);
    check_int(int_result, want, what);
    check_flags(flag_nv, flag_nx, want_nv, want_nx, what);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_int_to_single();
    round_mode_e mode;
    logic        neg;
    logic [63:0] value;
    for (int n = 0; n < 2; n++) begin
      for (int m = 0; m < 5; m++) begin
        neg   = n[0];
        mode  = round_mode_e'(m[2:0]);
        value = neg ? -64'd16777217 : 64'd16777217;   // 2^24 + 1, halfway between singles
        run_fp(FCVT_S_W, mode, value, 64'd0, boxed({neg, 8'h97, 22'd0, tie_away(neg, mode)}),
               1'b0, 1'b1, $sformatf("int tie to single, neg=%b %s", neg, mode.name()));
      end
    end
    run_fp(FCVT_S_W, RNE, 64'd0, 64'd0, boxed(32'd0), 1'b0, 1'b0, "int zero to single");
  endtask

  task automatic test_single_to_int();
    run_int(FCVT_W_S, boxed(32'h3FC0_0000), 64'd1, 1'b0, 1'b1, "1.5 to int32");
    run_int(FCVT_W_S, boxed(32'hC040_0000), 64'hFFFF_FFFF_FFFF_FFFD, 1'b0, 1'b0, "-3.0 to int32");
    run_int(FCVT_W_S, boxed(32'h7FC0_0000), 64'h7FFF_FFFF, 1'b1, 1'b0, "NaN to int32");
    run_int(FCVT_WU_S, boxed(32'hBF80_0000), 64'd0, 1'b0, 1'b1, "-1.0 to uint32");
    run_int(FCVT_W_S, boxed(32'h5380_0000), 64'h7FFF_FFFF, 1'b1, 1'b0, "2^40 to int32");
  endtask

  task automatic test_resize();
    run_fp(FCVT_D_S, RNE, 64'd0, boxed(32'h3F80_0000), $realtobits(1.0),
           1'b0, 1'b0, "1.0 to double");
    run_fp(FCVT_D_S, RNE, 64'd0, boxed(32'h7F80_0000), 64'h7FF0_0000_0000_0000,
           1'b0, 1'b0, "inf to double");
    run_fp(FCVT_S_D, RNE, 64'd0, $realtobits(1.0), boxed(32'h3F80_0000),
           1'b0, 1'b0, "1.0 to single");
    run_fp(FCVT_S_D, RNE, 64'd0, $realtobits(1.0e300), boxed(32'h7F80_0000),
           1'b0, 1'b1, "1e300 to single");
    run_fp(FCVT_S_D, RNE, 64'd0, $realtobits(1.0e-300), boxed(32'd0),
           1'b0, 1'b1, "1e-300 to single");
    // Negative NaN with a payload, sign and payload must not survive
    run_fp(FCVT_S_D, RNE, 64'd0, 64'hFFF8_0000_0000_1234, boxed(32'h7FC0_0000),
           1'b0, 1'b0, "NaN to single");
  endtask

  // Integers below 2^24 are exact in single precision
  task automatic test_round_trip();
    logic [31:0] bits;
    logic [63:0] value;
    logic [63:0] single_bits;
    for (int i = 0; i < 16; i++) begin
      bits  = rand_bits(24);
      value = {40'd0, bits[23:0]};
      if (rand_bits(1) != 32'd0) value = -value;
      convert(FCVT_S_W, RNE, value, 64'd0);
      check_flags(flag_nv, flag_nx, 1'b0, 1'b0, "round trip to single");
      single_bits = fp_result;
      check_int({32'd0, single_bits[63:32]}, 64'hFFFF_FFFF, "round trip NaN box");
      run_int(FCVT_W_S, single_bits, value, 1'b0, 1'b0, "round trip back to int32");
    end
  endtask

  // Back to back starts, results in order on consecutive cycles
  task automatic test_pipeline();
    drive_req(FCVT_S_W, RNE, 64'd5, 64'd0);
    drive_req(FCVT_W_S, RTZ, 64'd0, boxed(32'hC040_0000));
    @(negedge clk);
    check_strobes(done, busy, 1'b0, 1'b1, "pipeline fill");
    drive_req(FCVT_D_S, RNE, 64'd0, boxed(32'h3F80_0000));
    @(negedge clk);
    check_strobes(done, busy, 1'b0, 1'b1, "pipeline fill");
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_strobes(done, busy, 1'b1, 1'b1, "pipeline first result");
    check_fp(fp_result, boxed(32'h40A0_0000), "pipeline first result");
    @(negedge clk);
    check_strobes(done, busy, 1'b1, 1'b1, "pipeline second result");
    check_int(int_result, 64'hFFFF_FFFF_FFFF_FFFD, "pipeline second result");
    check_fp(fp_result, boxed(32'h40A0_0000), "fp_result held over int op");
    @(negedge clk);
    check_strobes(done, busy, 1'b1, 1'b1, "pipeline third result");
    check_fp(fp_result, $realtobits(1.0), "pipeline third result");
    check_int(int_result, 64'hFFFF_FFFF_FFFF_FFFD, "int_result held over fp op");
    @(negedge clk);
    check_strobes(done, busy, 1'b0, 1'b0, "pipeline drained");
  endtask

  initial begin
    reset_n     = 1'b0;
    start       = 1'b0;
    op          = FCVT_W_S;
    rm          = RNE;
    int_operand = '0;
    fp_operand  = '0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_strobes(done, busy, 1'b0, 1'b0, "after reset");
    check_fp(fp_result, 64'd0, "after reset");
    check_int(int_result, 64'd0, "after reset");
    check_flags(flag_nv, flag_nx, 1'b0, 1'b0, "after reset");
    test_int_to_single();
    test_single_to_int();
    test_resize();
    test_round_trip();
    test_pipeline();
    $display("Simulation passed");
    $finish;
  end

endmodule
